// ==== filelist.f ====
+incdir+rtl
rtl/ramio_pkg.sv
rtl/cache.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/ramio.sv
verif/burst_ram_model.sv
verif/ramio_assertions.sv
verif/ramio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ramio_tb -f filelist.f -o ramio_sim \
  || exit 1
out=$(./obj_dir/ramio_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1

// ==== verif/ramio_tb.sv ====
//----------------------------------------------------------------------
// ramio testbench
// directed memory, led and uart tests against a shadow byte model
//----------------------------------------------------------------------
`include "ramio_config.svh"
`default_nettype none

module ramio_tb
  import ramio_pkg::*;
;

  localparam int CPB          = `RAMIO_CLKS_PER_BIT;
  localparam int MISS_CYCLES  = `RAMIO_RAM_RD_DELAY + 8;
  localparam int FRAME_CYCLES = 10 * CPB;
  // about 60 accesses and 4 frame times in all, with margin
  localparam int CYCLE_LIMIT  = 8 + 80 * MISS_CYCLES + 4 * 2 * FRAME_CYCLES + 200;

  logic        clk;
  logic        rst_n;
  logic        enable;
  read_req_t   rd;
  write_req_t  wr;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic [3:0]  led;
  logic        uart_tx;
  logic        uart_rx;
  logic        br_cmd_en;
  br_cmd_t     br_cmd;
  logic [63:0] br_rd_data;
  logic        br_rd_data_valid;

  int          errors;
  int          cycles;
  integer      seed;
  logic [7:0]  shadow [0:8191];

  ramio dut_i (
    .clk (clk), .rst_n (rst_n), .enable (enable), .rd (rd), .wr (wr),
    .address (address), .data_in (data_in), .data_out (data_out),
    .data_out_ready (data_out_ready), .busy (busy), .led (led),
    .uart_tx (uart_tx), .uart_rx (uart_rx), .br_cmd_en (br_cmd_en),
    .br_cmd (br_cmd), .br_rd_data (br_rd_data), .br_rd_data_valid (br_rd_data_valid)
  );

  burst_ram_model ram_i (
    .clk (clk), .rst_n (rst_n), .cmd_en (br_cmd_en), .cmd (br_cmd),
    .rd_data (br_rd_data), .rd_data_valid (br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [`RAMIO_DATA_W-1:0] exp,
                            input logic [`RAMIO_DATA_W-1:0] act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_led(input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act) begin
      $display("FAIL t=%0t led expected %h actual %h", $time, exp, act);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // shadow update, misaligned halves and words change nothing
  task automatic shadow_write(input logic [31:0] a, input access_size_e size,
                              input logic [31:0] d);
    if (size == acc_byte) begin
      shadow[a[12:0]] = d[7:0];
    end else if (size == acc_half && !a[0]) begin
      shadow[a[12:0]]     = d[7:0];
      shadow[a[12:0] + 1] = d[15:8];
    end else if (size == acc_word && a[1:0] == 2'b00) begin
      for (int i = 0; i < 4; i++) begin
        shadow[a[12:0] + 13'(i)] = d[i * 8 +: 8];
      end
    end
  endtask

  function automatic logic [31:0] expect_read(input logic [31:0] a, input access_size_e size,
                                              input logic sign);
    logic [7:0]  b;
    logic [15:0] h;
    b = shadow[a[12:0]];
    h = {shadow[a[12:0] + 1], b};
    if (size == acc_byte) begin
      return sign ? {{24{b[7]}}, b} : {24'h0, b};
    end else if (size == acc_half) begin
      if (a[0]) return 32'h0;
      return sign ? {{16{h[15]}}, h} : {16'h0, h};
    end
    if (a[1:0] != 2'b00) return 32'h0;
    return {shadow[a[12:0] + 3], shadow[a[12:0] + 2], h};
  endfunction

  // waits for data_out_ready; busy covers a miss from the cycle after enable
  task automatic wait_done();
    int n;
    n = 0;
    @(negedge clk);
    while (!data_out_ready) begin
      if (n > 0) check_flag("busy", 1'b1, busy);
      n++;
      @(negedge clk);
    end
    check_flag("busy", 1'b0, busy);
  endtask

  task automatic mem_write(input logic [31:0] a, input access_size_e size,
                           input logic [31:0] d);
    @(posedge clk);
    enable  <= 1'b1;
    address <= a;
    data_in <= d;
    wr      <= '{size: size};
    rd      <= '{sign_ext: 1'b0, size: acc_none};
    wait_done();
    @(posedge clk);
    enable <= 1'b0;
    wr     <= '{size: acc_none};
    if (a < 32'h2000) shadow_write(a, size, d);
  endtask

  task automatic mem_read(input logic [31:0] a, input access_size_e size, input logic sign,
                          output logic [31:0] d);
    @(posedge clk);
    enable  <= 1'b1;
    address <= a;
    rd      <= '{sign_ext: sign, size: size};
    wr      <= '{size: acc_none};
    wait_done();
    d = data_out;
    @(posedge clk);
    enable <= 1'b0;
    rd     <= '{sign_ext: 1'b0, size: acc_none};
  endtask

  task automatic read_check(input logic [31:0] a, input access_size_e size, input logic sign);
    logic [31:0] d;
    mem_read(a, size, sign, d);
    check_word($sformatf("data_out@%h", a), expect_read(a, size, sign), d);
  endtask

  // each bit held for one bit time
  task automatic uart_send_frame(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (CPB - 1) @(posedge clk);
    end
  endtask

  task automatic uart_capture_frame(input logic [7:0] exp);
    logic [7:0] b;
    @(negedge clk);
    while (uart_tx) @(negedge clk);
    // to the middle of the start bit
    repeat (CPB / 2) @(negedge clk);
    if (uart_tx !== 1'b0) begin
      $display("uart_tx start bit was not low at mid bit");
      errors++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge clk);
      b[i] = uart_tx;
    end
    repeat (CPB) @(negedge clk);
    if (uart_tx !== 1'b1) begin
      $display("uart_tx stop bit was not high at mid bit");
      errors++;
    end
    check_byte("uart_tx frame", exp, b);
  endtask

  task automatic test_random_words();
    logic [31:0] addrs [12];
    for (int i = 0; i < 12; i++) begin
      addrs[i] = $random(seed) & 32'h0000_1ffc;
      mem_write(addrs[i], acc_word, $random(seed));
    end
    for (int i = 0; i < 12; i++) read_check(addrs[i], acc_word, 1'b0);
  endtask

  task automatic test_sub_word();
    logic [31:0] base;
    base = 32'h200;
    mem_write(base, acc_word, 32'h0);
    mem_write(base + 0, acc_byte, $random(seed));
    mem_write(base + 1, acc_byte, 32'ha5);
    mem_write(base + 2, acc_byte, 32'h3c);
    mem_write(base + 3, acc_byte, $random(seed) | 32'h80);
    // misaligned half leaves the word alone
    mem_write(base + 1, acc_half, 32'hdead);
    for (int l = 0; l < 4; l++) begin
      read_check(base + l, acc_byte, 1'b0);
      read_check(base + l, acc_byte, 1'b1);
    end
    mem_write(base + 2, acc_half, 32'h8001);
    for (int l = 0; l < 4; l += 2) begin
      read_check(base + l, acc_half, 1'b0);
      read_check(base + l, acc_half, 1'b1);
    end
    read_check(base + 1, acc_half, 1'b1);
    read_check(base, acc_word, 1'b0);
  endtask

  // same index, four tags: every write after the first evicts a dirty line
  task automatic test_eviction();
    for (int i = 0; i < 4; i++) mem_write(32'h400 + 32'(i) * 32'h20, acc_word, $random(seed));
    for (int i = 0; i < 4; i++) read_check(32'h400 + 32'(i) * 32'h20, acc_word, 1'b0);
  endtask

  task automatic test_led();
    mem_write(`RAMIO_ADDR_LED, acc_word, 32'h0000_00a5);
    // led register updates on the edge that ends the access
    @(negedge clk);
    check_led(4'h5, led);
    mem_write(32'h300, acc_word, 32'h0000_000a);
    read_check(32'h300, acc_word, 1'b0);
    @(negedge clk);
    check_led(4'h5, led);
  endtask

  task automatic test_uart_out();
    logic [31:0] d;
    mem_write(`RAMIO_ADDR_UART_OUT, acc_word, 32'h1234_565a);
    fork
      uart_capture_frame(8'h5a);
      begin
        repeat (3 * CPB) @(posedge clk);
        mem_read(`RAMIO_ADDR_UART_OUT, acc_word, 1'b0, d);
        check_word("uart out during frame", 32'h0000_005a, d);
      end
    join
    repeat (2 * CPB) @(posedge clk);
    mem_read(`RAMIO_ADDR_UART_OUT, acc_word, 1'b0, d);
    check_word("uart out after frame", 32'hffff_ffff, d);
  endtask

  task automatic test_uart_in();
    logic [31:0] d;
    uart_send_frame(8'hc3);
    repeat (4) @(posedge clk);
    mem_read(`RAMIO_ADDR_UART_IN, acc_word, 1'b0, d);
    check_word("uart in first read", 32'h0000_00c3, d);
    mem_read(`RAMIO_ADDR_UART_IN, acc_word, 1'b0, d);
    check_word("uart in second read", 32'hffff_ffff, d);
  endtask

  initial begin
    errors  = 0;
    cycles  = 0;
    seed    = 78277;
    rst_n   = 1'b0;
    enable  = 1'b0;
    rd      = '{sign_ext: 1'b0, size: acc_none};
    wr      = '{size: acc_none};
    address = 32'h0;
    data_in = 32'h0;
    uart_rx = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_random_words();
    test_sub_word();
    test_eviction();
    test_led();
    test_uart_out();
    test_uart_in();
    repeat (4) @(posedge clk);
    $display("summary: %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/ramio_assertions.sv ====
//----------------------------------------------------------------------
// ramio assertions
// ram command pulses and the memory ready/busy relation
//----------------------------------------------------------------------
`default_nettype none

module ramio_assertions (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire is_io,
  input wire br_cmd_en,
  input wire data_out_ready,
  input wire busy
);

  // commands are single cycle pulses
  a_cmd_single: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en)
    else $error("br_cmd_en high on two cycles in a row");

  // a memory result is never out while still busy
  a_ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && !is_io && data_out_ready) |-> !busy)
    else $error("data_out_ready and busy both high for a memory access");

endmodule

bind ramio ramio_assertions ramio_assertions_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .enable         (enable),
  .is_io          (is_io),
  .br_cmd_en      (br_cmd_en),
  .data_out_ready (data_out_ready),
  .busy           (busy)
);

`default_nettype wire

// ==== verif/burst_ram_model.sv ====
//----------------------------------------------------------------------
// burst ram model
// 64-bit words, writes land on the command, reads answer after a delay
//----------------------------------------------------------------------
`include "ramio_config.svh"
`default_nettype none

module burst_ram_model
  import ramio_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         cmd_en,
  input  wire br_cmd_t cmd,
  output logic [63:0] rd_data,
  output logic        rd_data_valid
);

  localparam int DEPTH = 1 << `RAMIO_RAM_ADDR_W;

  logic [63:0]                  mem [DEPTH];
  logic [`RAMIO_RAM_ADDR_W-1:0] rd_addr;
  int unsigned                  rd_cnt;

  // fill pattern built from the whole word address
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i)};
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      rd_cnt        <= 0;
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= 1'b0;
      if (rd_cnt != 0) begin
        rd_cnt <= rd_cnt - 1;
        if (rd_cnt == 1) begin
          rd_data_valid <= 1'b1;
          rd_data       <= mem[rd_addr];
        end
      end
      if (cmd_en) begin
        if (cmd.write) begin
          // a set mask bit keeps the old byte
          for (int b = 0; b < 8; b++) begin
            if (!cmd.data_mask[b]) begin
              mem[cmd.addr][b * 8 +: 8] <= cmd.wr_data[b * 8 +: 8];
            end
          end
        end else begin
          rd_addr <= cmd.addr;
          rd_cnt  <= `RAMIO_RAM_RD_DELAY;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ramio.sv ====
//----------------------------------------------------------------------
// ramio bridge
// decodes leds and uart words, routes the rest to the cache, aligns
// write lanes and extends read data by access size
//----------------------------------------------------------------------
`include "ramio_config.svh"
`default_nettype none

module ramio
  import ramio_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      enable,
  input  wire read_req_t           rd,
  input  wire write_req_t          wr,
  input  wire [`RAMIO_ADDR_W-1:0]  address,
  input  wire [`RAMIO_DATA_W-1:0]  data_in,
  output logic [`RAMIO_DATA_W-1:0] data_out,
  output logic                     data_out_ready,
  output logic                     busy,
  output logic [3:0]               led,
  output logic                     uart_tx,
  input  wire                      uart_rx,
  output logic                     br_cmd_en,
  output br_cmd_t                  br_cmd,
  input  wire [63:0]               br_rd_data,
  input  wire                      br_rd_data_valid
);

  // address decode, done once
  logic is_led;
  logic is_out;
  logic is_in;
  logic is_io;
  logic rd_req;
  logic wr_req;

  assign is_led = (address == `RAMIO_ADDR_LED);
  assign is_out = (address == `RAMIO_ADDR_UART_OUT);
  assign is_in  = (address == `RAMIO_ADDR_UART_IN);
  assign is_io  = is_led || is_out || is_in;
  assign rd_req = enable && (rd.size != acc_none);
  assign wr_req = enable && (wr.size != acc_none);

  // cache side
  logic                     cache_en;
  logic [`RAMIO_ADDR_W-1:0] cache_address;
  logic [`RAMIO_DATA_W-1:0] cache_data_in;
  logic [3:0]               cache_we;
  logic [`RAMIO_DATA_W-1:0] cache_data_out;
  logic                     cache_data_out_ready;
  logic                     cache_busy;

  assign cache_en      = enable && !is_io;
  assign cache_address = {address[`RAMIO_ADDR_W-1:2], 2'b00};

  // i/o answers in the same cycle
  assign busy           = is_io ? 1'b0 : cache_busy;
  assign data_out_ready = is_io ? 1'b1 : cache_data_out_ready;

  // write lanes: data is replicated, the byte enable picks the lane
  always_comb begin
    cache_data_in = data_in;
    cache_we      = 4'b0000;
    unique case (wr.size)
      acc_byte: begin
        cache_data_in = {4{data_in[7:0]}};
        cache_we      = 4'b0001 << address[1:0];
      end
      acc_half: begin
        cache_data_in = {2{data_in[15:0]}};
        // odd half-word address writes nothing
        if (!address[0]) begin
          cache_we = 4'b0011 << address[1:0];
        end
      end
      acc_word: begin
        if (address[1:0] == 2'b00) begin
          cache_we = 4'b1111;
        end
      end
      default: ;
    endcase
  end

  // read: lane at address[1:0] moved down, then extended
  logic [`RAMIO_DATA_W-1:0] lane;
  logic [`RAMIO_DATA_W-1:0] mem_data;
  logic [`RAMIO_DATA_W-1:0] uart_out_reg;
  logic [`RAMIO_DATA_W-1:0] uart_in_reg;

  assign lane = cache_data_out >> {address[1:0], 3'b000};

  always_comb begin
    unique case (rd.size)
      acc_byte: mem_data = {{24{rd.sign_ext & lane[7]}}, lane[7:0]};
      acc_half: mem_data = address[0] ? '0 : {{16{rd.sign_ext & lane[15]}}, lane[15:0]};
      acc_word: mem_data = (address[1:0] == 2'b00) ? lane : '0;
      default:  mem_data = '0;
    endcase
  end

  always_comb begin
    data_out = '0;
    if (rd_req) begin
      if (is_out) begin
        data_out = uart_out_reg;
      end else if (is_in) begin
        data_out = uart_in_reg;
      end else if (is_led) begin
        data_out = {28'h0, led};
      end else begin
        data_out = mem_data;
      end
    end
  end

  // uart handshake levels
  logic       tx_go;
  logic       tx_go_prev;
  logic       tx_bsy;
  logic       rx_go;
  logic       rx_data_ready;
  logic [7:0] rx_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led          <= 4'b1111;
      uart_out_reg <= '1;
      uart_in_reg  <= '1;
      tx_go        <= 1'b0;
      tx_go_prev   <= 1'b0;
      rx_go        <= 1'b1;
    end else begin
      tx_go_prev <= 1'b0;
      // reading uart in empties it
      if (rd_req && is_in) begin
        uart_in_reg <= '1;
      end
      // new byte wins over the clear, go drops one cycle as acknowledge
      if (rx_go && rx_data_ready) begin
        uart_in_reg <= {24'h0, rx_data};
        rx_go       <= 1'b0;
      end else if (!rx_go) begin
        rx_go <= 1'b1;
      end
      // transmitter done; bsy is not up yet in the cycle after go rose
      if (tx_go && !tx_bsy && !tx_go_prev) begin
        tx_go        <= 1'b0;
        uart_out_reg <= '1;
      end
      if (wr_req && is_out) begin
        uart_out_reg <= {24'h0, data_in[7:0]};
        tx_go        <= 1'b1;
        tx_go_prev   <= 1'b1;
      end
      // leds are active low, written as given
      if (wr_req && is_led) begin
        led <= data_in[3:0];
      end
    end
  end

  cache cache_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .en               (cache_en),
    .address          (cache_address),
    .data_in          (cache_data_in),
    .write_enable     (cache_we),
    .data_out         (cache_data_out),
    .data_out_ready   (cache_data_out_ready),
    .busy             (cache_busy),
    .br_cmd_en        (br_cmd_en),
    .br_cmd           (br_cmd),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  uart_tx #(.CLKS_PER_BIT(`RAMIO_CLKS_PER_BIT)) uart_tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (tx_go),
    .data  (uart_out_reg[7:0]),
    .tx    (uart_tx),
    .bsy   (tx_bsy)
  );

  uart_rx #(.CLKS_PER_BIT(`RAMIO_CLKS_PER_BIT)) uart_rx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_data),
    .data_ready (rx_data_ready)
  );

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
//----------------------------------------------------------------------
// uart receiver, 8N1
// samples mid bit, drops frames with a bad stop bit
//----------------------------------------------------------------------
`default_nettype none

module uart_rx
  import ramio_pkg::*;
#(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

  uart_state_e      state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  // [0],[1] synchronizer, [2] previous synced level for edge detect
  logic [2:0]       rx_sync;
  logic             rx_s;
  logic             bit_end;

  assign rx_s    = rx_sync[1];
  assign bit_end = (cnt == BIT_END);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= us_idle;
      rx_sync    <= 3'b111;
      cnt        <= '0;
      bit_idx    <= '0;
      data_ready <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
      // go low is the acknowledge
      if (!go) begin
        data_ready <= 1'b0;
      end
      unique case (state)
        us_idle: begin
          // falling edge starts a frame
          if (rx_sync[2] && !rx_s) begin
            cnt   <= '0;
            state <= us_start;
          end
        end
        us_start: begin
          // half a bit in, start bit must still be low, else it was a glitch
          if (cnt == HALF_END) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_s ? us_idle : us_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        us_data: begin
          if (bit_end) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= us_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        us_stop: begin
          if (bit_end) begin
            state <= us_idle;
            if (rx_s) begin
              data_ready <= 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // data bits shift in from the top, lsb first on the line
  always_ff @(posedge clk) begin
    if (state == us_data && bit_end) begin
      shift <= {rx_s, shift[7:1]};
    end
    if (state == us_stop && bit_end && rx_s) begin
      data <= shift;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
//----------------------------------------------------------------------
// uart transmitter, 8N1
// sends one byte per go, bsy high while the frame is on the line
//----------------------------------------------------------------------
`default_nettype none

module uart_tx
  import ramio_pkg::*;
#(
  parameter int CLKS_PER_BIT = 8
) (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       go,
  input  wire [7:0] data,
  output logic      tx,
  output logic      bsy
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

  uart_state_e      state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= us_idle;
      tx      <= 1'b1;
      bsy     <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      unique case (state)
        us_idle: begin
          if (go) begin
            // start bit goes out right away
            tx    <= 1'b0;
            bsy   <= 1'b1;
            cnt   <= '0;
            state <= us_start;
          end
        end
        us_start: begin
          if (cnt == BIT_END) begin
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= shift[0];
            state   <= us_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        us_data: begin
          if (cnt == BIT_END) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;
              state <= us_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= shift[1];
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        us_stop: begin
          // stop bit done: drop bsy, then hold until go is released
          if (cnt == BIT_END) begin
            bsy <= 1'b0;
            if (!go) begin
              state <= us_idle;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // byte latched on go, lsb first
  always_ff @(posedge clk) begin
    if (state == us_idle && go) begin
      shift <= data;
    end else if (state == us_data && cnt == BIT_END) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cache.sv ====
//----------------------------------------------------------------------
// direct-mapped write-back cache
// 32-bit word port in front of a 64-bit burst ram, one word per line
//----------------------------------------------------------------------
`include "ramio_config.svh"
`default_nettype none

module cache
  import ramio_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      en,
  input  wire [`RAMIO_ADDR_W-1:0]  address,
  input  wire [`RAMIO_DATA_W-1:0]  data_in,
  input  wire [3:0]                write_enable,
  output logic [`RAMIO_DATA_W-1:0] data_out,
  output logic                     data_out_ready,
  output logic                     busy,
  output logic                     br_cmd_en,
  output br_cmd_t                  br_cmd,
  input  wire [63:0]               br_rd_data,
  input  wire                      br_rd_data_valid
);

  localparam int IDX_W = `RAMIO_CACHE_IDX_W;
  localparam int TAG_W = `RAMIO_RAM_ADDR_W - IDX_W;
  localparam int LINES = 1 << IDX_W;

  // line storage
  logic [63:0]      line_data  [LINES];
  logic [TAG_W-1:0] line_tag   [LINES];
  logic [LINES-1:0] line_valid;
  logic [LINES-1:0] line_dirty;

  cache_state_e state;

  // address split: | tag | index | word | byte |
  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic             word_sel;
  logic             hit;
  logic             lookup;
  logic [63:0]      merged;

  assign word_sel = address[2];
  assign idx      = address[3 +: IDX_W];
  assign tag      = address[3 + IDX_W +: TAG_W];
  assign hit      = line_valid[idx] && (line_tag[idx] == tag);

  // a request is looked at only in idle, and not in the cycle its result is out,
  // since the client still holds it then
  assign lookup = (state == cs_idle) && en && !data_out_ready;

  // current line with the enabled bytes of data_in merged into the selected word
  always_comb begin
    merged = line_data[idx];
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        merged[word_sel * 32 + b * 8 +: 8] = data_in[b * 8 +: 8];
      end
    end
  end

  // control: state, valid/dirty bits and handshake levels
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= cs_idle;
      line_valid     <= '0;
      line_dirty     <= '0;
      busy           <= 1'b0;
      data_out_ready <= 1'b0;
      br_cmd_en      <= 1'b0;
    end else begin
      // commands and ready are single cycle pulses
      br_cmd_en      <= 1'b0;
      data_out_ready <= 1'b0;
      unique case (state)
        cs_idle: begin
          if (lookup && hit) begin
            data_out_ready <= 1'b1;
            busy           <= 1'b0;
            if (|write_enable) begin
              line_dirty[idx] <= 1'b1;
            end
          end else if (lookup) begin
            busy <= 1'b1;
            // dirty victim goes out first
            if (line_valid[idx] && line_dirty[idx]) begin
              br_cmd_en <= 1'b1;
              state     <= cs_write_back;
            end else begin
              state <= cs_fill_req;
            end
          end
        end
        // write-back command is on the bus this cycle
        cs_write_back: state <= cs_fill_req;
        cs_fill_req: begin
          br_cmd_en <= 1'b1;
          state     <= cs_fill_wait;
        end
        cs_fill_wait: begin
          if (br_rd_data_valid) begin
            line_valid[idx] <= 1'b1;
            line_dirty[idx] <= 1'b0;
            // back to idle, the held request then hits
            state <= cs_idle;
          end
        end
      endcase
    end
  end

  // payload: line data, tags, read word and ram command
  always_ff @(posedge clk) begin
    if (lookup && hit) begin
      line_data[idx] <= merged;
      data_out       <= word_sel ? merged[63:32] : merged[31:0];
    end
    if (state == cs_fill_wait && br_rd_data_valid) begin
      line_data[idx] <= br_rd_data;
      line_tag[idx]  <= tag;
    end
    if (lookup && !hit) begin
      // victim address rebuilt from its stored tag
      br_cmd <= '{write: 1'b1, addr: {line_tag[idx], idx},
                  wr_data: line_data[idx], data_mask: 8'h00};
    end
    if (state == cs_fill_req) begin
      br_cmd <= '{write: 1'b0, addr: address[3 +: `RAMIO_RAM_ADDR_W],
                  wr_data: line_data[idx], data_mask: 8'h00};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ramio_pkg.sv ====
//----------------------------------------------------------------------
// ramio types
// access request encodings, burst ram command and fsm states
//----------------------------------------------------------------------
`include "ramio_config.svh"
`default_nettype none

package ramio_pkg;

  // size of a client access, none means no read or no write
  typedef enum logic [1:0] {
    acc_none = 2'd0,
    acc_byte = 2'd1,
    acc_half = 2'd2,
    acc_word = 2'd3
  } access_size_e;

  // read request, sign_ext only matters for byte and half
  typedef struct packed {
    logic         sign_ext;
    access_size_e size;
  } read_req_t;

  typedef struct packed {
    access_size_e size;
  } write_req_t;

  // one command to the burst ram, valid while br_cmd_en is high
  typedef struct packed {
    logic                         write;
    logic [`RAMIO_RAM_ADDR_W-1:0] addr;
    logic [63:0]                  wr_data;
    logic [7:0]                   data_mask;
  } br_cmd_t;

  typedef enum logic [1:0] {
    cs_idle       = 2'd0,
    cs_write_back = 2'd1,
    cs_fill_req   = 2'd2,
    cs_fill_wait  = 2'd3
  } cache_state_e;

  // shared by transmitter and receiver
  typedef enum logic [1:0] {
    us_idle  = 2'd0,
    us_start = 2'd1,
    us_data  = 2'd2,
    us_stop  = 2'd3
  } uart_state_e;

endpackage

`default_nettype wire

// ==== rtl/ramio_config.svh ====
//----------------------------------------------------------------------
// ramio configuration
// address widths, cache geometry, i/o map and uart bit timing
//----------------------------------------------------------------------
`ifndef RAMIO_CONFIG_SVH
`define RAMIO_CONFIG_SVH

// client side bus widths
`define RAMIO_ADDR_W 32
`define RAMIO_DATA_W 32

// burst ram depth, addressed in 64-bit words
`define RAMIO_RAM_ADDR_W 10

// 2^n lines of 8 bytes each
`define RAMIO_CACHE_IDX_W 2

// memory mapped i/o words at the top of the address space
`define RAMIO_ADDR_LED 32'hffff_fffc
`define RAMIO_ADDR_UART_OUT 32'hffff_fff8
`define RAMIO_ADDR_UART_IN 32'hffff_fff4

// clock / baud, kept small so simulation stays short
`define RAMIO_CLKS_PER_BIT 8

// read latency of the burst ram model, in clocks
`define RAMIO_RAM_RD_DELAY 4

`endif
